// File: Bender.yml
package:
  name: sfu

sources:
  - include_dirs:
      - design
    files:
      - design/sfu_pkg.sv
      - design/sfu_queue_if.sv
      - design/sfu_fifo.sv
      - design/sfu_decode.sv
      - design/sfu_execute.sv
      - design/sfu_result.sv
      - design/sfu_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/sfu_tb.sv

// File: design/sfu_cfg.svh
// ------------------
// sfu lane, width, shift and queue depth macros
// ------------------
`ifndef SFU_CFG_SVH
`define SFU_CFG_SVH

// lanes per row
`define SFU_COL        8

// operand width, also the width-8 pairing shift
`define SFU_BW         4

// partial sum lane width
`define SFU_PSUM_W     12

// local row sum, zero-extended lane total
`define SFU_SUM_W      16

// left shift ahead of the divide
`define SFU_FRAC_W     12

// entries per queue, keep a power of two
`define SFU_FIFO_DEPTH 16

`endif

// File: design/sfu_decode.sv
// ------------------
// lane magnitudes, width-8 pairing, row sum
// ------------------
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_decode (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          acc,
  input  logic          ofifo_valid,
  input  logic          width_mode,
  input  logic          sign_mode,
  input  sfu_pkg::row_u sfp_in,
  output sfu_pkg::row_u row,
  output sfu_pkg::sum_t row_sum,
  output logic          push
);
  import sfu_pkg::*;

  localparam int PW = `SFU_PSUM_W;

  psum_t [`SFU_COL-1:0]   mag;
  wide_t [`SFU_COL/2-1:0] pair;

  // magnitude per lane, two's complement abs only in sign mode
  always_comb begin
    for (int i = 0; i < `SFU_COL; i++) begin
      if (sign_mode && sfp_in.lanes4[i][PW-1]) begin
        mag[i] = -sfp_in.lanes4[i];
      end else begin
        mag[i] = sfp_in.lanes4[i];
      end
    end
  end

  // zero-extended total of the magnitudes
  always_comb begin
    row_sum = '0;
    for (int i = 0; i < `SFU_COL; i++) begin
      row_sum = row_sum + sum_t'(mag[i]);
    end
  end

  // odd lane is the high part, shifted by the operand width
  always_comb begin
    for (int i = 0; i < `SFU_COL/2; i++) begin
      psum_t hi;
      psum_t lo;
      wide_t hi_ext;
      wide_t lo_ext;
      hi     = sfp_in.lanes4[2*i+1];
      lo     = sfp_in.lanes4[2*i];
      // raw lanes here, not magnitudes
      hi_ext = sign_mode ? {{PW{hi[PW-1]}}, hi} : {{PW{1'b0}}, hi};
      lo_ext = sign_mode ? {{PW{lo[PW-1]}}, lo} : {{PW{1'b0}}, lo};
      pair[i] = (hi_ext << `SFU_BW) + lo_ext;
    end
  end

  // storage word follows width_mode at push time
  always_comb begin
    if (width_mode) begin
      row.lanes8 = pair;
    end else begin
      row.lanes4 = mag;
    end
  end

  // one row per strobe while output fifo has data
  assign push = acc && ofifo_valid;

  // upstream row must be fully driven when it is taken
  a_row_known: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !$isunknown({sfp_in, width_mode, sign_mode}))
    else $error("sfu_decode: unknown row or mode at push");

endmodule

// File: design/sfu_execute.sv
// ------------------
// value, sum and share queues with pop control
// ------------------
`timescale 1ns/1ps

module sfu_execute (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          push,
  input  sfu_pkg::row_u row,
  input  sfu_pkg::sum_t row_sum,
  input  logic          div,
  input  sfu_pkg::sum_t peer_sum,
  input  logic          peer_empty,
  input  logic          share_rd,
  output sfu_pkg::sum_t share_sum,
  output logic          share_empty,
  sfu_queue_if.exec     q
);
  import sfu_pkg::*;

  logic value_empty;
  logic sum_empty;
  logic ready;

  // decoded rows
  sfu_fifo #(.WIDTH($bits(row_u))) value_q (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (push),
    .rd    (q.pop),
    .din   (row),
    .dout  (q.head_row),
    .empty (value_empty),
    .full  ()
  );

  // local sums in step with value_q
  sfu_fifo #(.WIDTH($bits(sum_t))) sum_q (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (push),
    .rd    (q.pop),
    .din   (row_sum),
    .dout  (q.head_sum),
    .empty (sum_empty),
    .full  ()
  );

  // copy for the peer core drained only by share_rd
  sfu_fifo #(.WIDTH($bits(sum_t))) share_q (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (push),
    .rd    (share_rd),
    .din   (row_sum),
    .dout  (share_sum),
    .empty (share_empty),
    .full  ()
  );

  // need both local heads and a peer total
  assign ready      = !value_empty && !sum_empty && !peer_empty;
  assign q.pop      = div && ready;
  assign q.peer_sum = peer_sum;

endmodule

// File: design/sfu_fifo.sv
// ------------------
// show-ahead single clock queue
// ------------------
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_fifo #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr,
  input  logic             rd,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);

  localparam int DEPTH = `SFU_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // entry storage
  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  // one extra bit to tell full from empty
  logic [AW:0]      count;
  logic             wr_en;
  logic             rd_en;

  // full queue drops the write
  assign wr_en = wr && !full;
  assign rd_en = rd && !empty;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers wrap on their own since depth is 2^AW
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head visible without a read
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == DEPTH[AW:0]);

  // upstream must respect full
  a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full)
    else $error("sfu_fifo: write while full, entry lost");

  // popper must respect empty
  a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty)
    else $error("sfu_fifo: read while empty");

endmodule

// File: design/sfu_pkg.sv
// ------------------
// sfu lane, sum and row types
// ------------------
`include "sfu_cfg.svh"

package sfu_pkg;

  // one partial sum lane
  typedef logic [`SFU_PSUM_W-1:0] psum_t;

  // local row sum
  typedef logic [`SFU_SUM_W-1:0] sum_t;

  // local plus peer, one bit of headroom
  typedef logic [`SFU_SUM_W:0] total_t;

  // width-8 word, two lanes fused
  typedef logic [2*`SFU_PSUM_W-1:0] wide_t;

  // same stored row, read per width_mode
  // lanes4 is eight lanes, lanes8 is four fused words
  typedef union packed {
    psum_t [`SFU_COL-1:0]   lanes4;
    wide_t [`SFU_COL/2-1:0] lanes8;
  } row_u;

endpackage

// File: design/sfu_queue_if.sv
// ------------------
// queue head bundle, execute to result
// ------------------
`timescale 1ns/1ps

interface sfu_queue_if;
  import sfu_pkg::*;

  // value queue head, raw storage word
  row_u  head_row;
  // matching local sum
  sum_t  head_sum;
  // peer core total, passed straight through
  sum_t  peer_sum;
  // head consumed this cycle
  logic  pop;

  // execute owns the heads
  modport exec (output head_row, output head_sum, output peer_sum, output pop);

  // result only reads
  modport res (input head_row, input head_sum, input peer_sum, input pop);

endinterface

// File: design/sfu_result.sv
// ------------------
// per-lane fraction divide, output select
// ------------------
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_result (
  input  logic          width_mode,
  sfu_queue_if.res      q,
  output sfu_pkg::row_u sfp_out,
  output logic          out_valid
);
  import sfu_pkg::*;

  localparam int NW = `SFU_PSUM_W + `SFU_FRAC_W;

  total_t total;
  row_u   norm;

  // two-core denominator
  assign total = total_t'(q.head_sum) + total_t'(q.peer_sum);

  // lane magnitude scaled up, then divided, low bits kept
  always_comb begin
    for (int i = 0; i < `SFU_COL; i++) begin
      logic [NW-1:0] num;
      logic [NW-1:0] quo;
      num = {q.head_row.lanes4[i], {`SFU_FRAC_W{1'b0}}};
      quo = num / total;
      norm.lanes4[i] = quo[`SFU_PSUM_W-1:0];
    end
  end

  // width-8 words pass through untouched
  assign sfp_out   = width_mode ? q.head_row : norm;
  assign out_valid = q.pop;

  // zero total is out of contract, catch it on the pop that uses it
  always_comb begin
    if (q.pop) begin
      a_total_nonzero: assert final (total != '0)
        else $error("sfu_result: zero divisor on pop");
    end
  end

endmodule

// File: design/sfu_top.sv
// ------------------
// sfu top, decode to execute to result
// ------------------
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             acc,
  input  logic                             div,
  input  logic                             width_mode,
  input  logic                             sign_mode,
  input  logic                             ofifo_valid,
  input  logic [`SFU_COL*`SFU_PSUM_W-1:0]  sfp_in,
  output logic [`SFU_COL*`SFU_PSUM_W-1:0]  sfp_out,
  output logic                             out_valid,
  input  logic [`SFU_SUM_W-1:0]            peer_sum,
  input  logic                             peer_empty,
  output logic                             peer_rd,
  input  logic                             share_rd,
  output logic [`SFU_SUM_W-1:0]            share_sum,
  output logic                             share_empty
);
  import sfu_pkg::*;

  row_u dec_row;
  sum_t dec_sum;
  logic push;

  sfu_queue_if q_if ();

  sfu_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .acc         (acc),
    .ofifo_valid (ofifo_valid),
    .width_mode  (width_mode),
    .sign_mode   (sign_mode),
    .sfp_in      (sfp_in),
    .row         (dec_row),
    .row_sum     (dec_sum),
    .push        (push)
  );

  sfu_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (push),
    .row         (dec_row),
    .row_sum     (dec_sum),
    .div         (div),
    .peer_sum    (peer_sum),
    .peer_empty  (peer_empty),
    .share_rd    (share_rd),
    .share_sum   (share_sum),
    .share_empty (share_empty),
    .q           (q_if.exec)
  );

  sfu_result u_result (
    .width_mode (width_mode),
    .q          (q_if.res),
    .sfp_out    (sfp_out),
    .out_valid  (out_valid)
  );

  // peer pops its share queue with our pop
  assign peer_rd = q_if.pop;

  // controller issues accumulate and divide phases apart
  a_acc_div_excl: assert property (@(posedge clk) disable iff (!rst_n) !(acc && div))
    else $error("sfu_top: acc and div high together");

endmodule

// File: sim/sfu_tb.sv
// --------------------
// sfu testbench with clock, reset, stimulus, peer model,
// expected-row model, assertions and closing report
// --------------------
`timescale 1ns/1ps
`include "sfu_cfg.svh"

module sfu_tb;

  localparam int ROW_W = `SFU_COL * `SFU_PSUM_W;
  localparam int MAX_ROWS = 64;
  localparam int WAIT_LIMIT = 200;

  logic clk;
  logic rst_n;
  logic acc;
  logic div;
  logic width_mode;
  logic sign_mode;
  logic ofifo_valid;
  logic [ROW_W-1:0] sfp_in;
  logic [ROW_W-1:0] sfp_out;
  logic out_valid;
  logic [`SFU_SUM_W-1:0] peer_sum;
  logic peer_empty;
  logic peer_rd;
  logic share_rd;
  logic [`SFU_SUM_W-1:0] share_sum;
  logic share_empty;

  // expected rows and sums in push order
  logic [ROW_W-1:0] exp_out [MAX_ROWS];
  logic [`SFU_SUM_W-1:0] exp_share [MAX_ROWS];
  int exp_wr;
  int push_count;
  int pop_count;
  int share_count;
  int check_errors;
  int timeout_errors;

  sfu_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .acc         (acc),
    .div         (div),
    .width_mode  (width_mode),
    .sign_mode   (sign_mode),
    .ofifo_valid (ofifo_valid),
    .sfp_in      (sfp_in),
    .sfp_out     (sfp_out),
    .out_valid   (out_valid),
    .peer_sum    (peer_sum),
    .peer_empty  (peer_empty),
    .peer_rd     (peer_rd),
    .share_rd    (share_rd),
    .share_sum   (share_sum),
    .share_empty (share_empty)
  );

  always #2 clk = ~clk;

  // push, pop and share read counters
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_count  <= 0;
      pop_count   <= 0;
      share_count <= 0;
    end else begin
      if (acc && ofifo_valid) push_count <= push_count + 1;
      if (out_valid) pop_count <= pop_count + 1;
      if (share_rd && !share_empty) share_count <= share_count + 1;
    end
  end

  task automatic flag_mismatch(input string msg);
    check_errors++;
    $display("CHECK FAILED t=%0t: %s", $time, msg);
  endtask

  // idle until the first push
  a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    push_count == 0 |-> !out_valid && share_empty)
    else flag_mismatch("activity before first push");

  // result row against the model head
  a_out_value: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> sfp_out == exp_out[pop_count])
    else flag_mismatch("sfp_out differs from expected row");

  a_out_expected: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> pop_count < exp_wr)
    else flag_mismatch("out_valid with no row queued");

  // no pop without a peer total
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    peer_empty |-> !out_valid)
    else flag_mismatch("out_valid while peer_empty");

  a_pop_ready: assert property (@(posedge clk) disable iff (!rst_n)
    div && !peer_empty && push_count > pop_count |-> out_valid)
    else flag_mismatch("div ignored with all queues ready");

  a_peer_rd: assert property (@(posedge clk) disable iff (!rst_n)
    peer_rd == out_valid)
    else flag_mismatch("peer_rd does not track out_valid");

  a_share_value: assert property (@(posedge clk) disable iff (!rst_n)
    share_rd |-> !share_empty && share_sum == exp_share[share_count])
    else flag_mismatch("share_sum differs from expected row sum");

  // drained share queue reads empty again
  a_share_drained: assert property (@(posedge clk) disable iff (!rst_n)
    share_count == push_count |-> share_empty)
    else flag_mismatch("share_empty low with share queue drained");

  // abs only when sign mode sees a negative lane
  function automatic int lane_magnitude(input logic [`SFU_PSUM_W-1:0] lane, input bit sgn);
    if (sgn && lane[`SFU_PSUM_W-1]) begin
      return (1 << `SFU_PSUM_W) - int'(lane);
    end
    return int'(lane);
  endfunction

  function automatic int lane_value(input logic [`SFU_PSUM_W-1:0] lane, input bit sgn);
    int v;
    v = int'(lane);
    if (sgn && lane[`SFU_PSUM_W-1]) v = v - (1 << `SFU_PSUM_W);
    return v;
  endfunction

  function automatic logic [`SFU_SUM_W-1:0] row_total(input logic [ROW_W-1:0] raw, input bit sgn);
    int sum;
    sum = 0;
    for (int i = 0; i < `SFU_COL; i++) begin
      sum += lane_magnitude(raw[i*`SFU_PSUM_W +: `SFU_PSUM_W], sgn);
    end
    return `SFU_SUM_W'(sum);
  endfunction

  // width-4 fractions or width-8 pair words from the raw input row
  function automatic logic [ROW_W-1:0] expected_output(input logic [ROW_W-1:0] raw,
      input bit w8, input bit sgn, input logic [`SFU_SUM_W-1:0] peer);
    logic [ROW_W-1:0] res;
    int hi;
    int lo;
    int total;
    longint quo;
    res = '0;
    if (w8) begin
      for (int i = 0; i < `SFU_COL/2; i++) begin
        hi = lane_value(raw[(2*i+1)*`SFU_PSUM_W +: `SFU_PSUM_W], sgn);
        lo = lane_value(raw[2*i*`SFU_PSUM_W +: `SFU_PSUM_W], sgn);
        res[i*2*`SFU_PSUM_W +: 2*`SFU_PSUM_W] = (2*`SFU_PSUM_W)'(hi * (1 << `SFU_BW) + lo);
      end
    end else begin
      total = int'(row_total(raw, sgn)) + int'(peer);
      for (int i = 0; i < `SFU_COL; i++) begin
        quo = (longint'(lane_magnitude(raw[i*`SFU_PSUM_W +: `SFU_PSUM_W], sgn))
               << `SFU_FRAC_W) / total;
        res[i*`SFU_PSUM_W +: `SFU_PSUM_W] = `SFU_PSUM_W'(quo);
      end
    end
    return res;
  endfunction

  function automatic logic [ROW_W-1:0] random_row(input int max_lane);
    logic [ROW_W-1:0] r;
    for (int i = 0; i < `SFU_COL; i++) begin
      r[i*`SFU_PSUM_W +: `SFU_PSUM_W] = `SFU_PSUM_W'($urandom_range(max_lane));
    end
    // lane 0 nonzero keeps the row sum above zero
    if (r[`SFU_PSUM_W-1:0] == '0) r[0] = 1'b1;
    return r;
  endfunction

  // push one row and record its expected result with the current modes
  task automatic push_row(input logic [ROW_W-1:0] raw);
    @(negedge clk);
    sfp_in      = raw;
    acc         = 1'b1;
    ofifo_valid = 1'b1;
    exp_out[exp_wr]   = expected_output(raw, width_mode, sign_mode, peer_sum);
    exp_share[exp_wr] = row_total(raw, sign_mode);
    exp_wr++;
    @(negedge clk);
    acc         = 1'b0;
    ofifo_valid = 1'b0;
  endtask

  // hold div until n more rows come out
  task automatic divide_rows(input int n);
    int target;
    int waited;
    target = pop_count + n;
    waited = 0;
    div = 1'b1;
    while (pop_count < target && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    div = 1'b0;
    if (pop_count < target) begin
      timeout_errors++;
      $display("timeout at %0t: only %0d of %0d rows came out", $time,
               n - (target - pop_count), n);
    end
  endtask

  // peer side reads every share entry
  task automatic drain_share();
    int waited;
    waited = 0;
    while (share_count < push_count && waited < WAIT_LIMIT) begin
      @(negedge clk);
      share_rd = !share_empty && (share_count < push_count);
      waited++;
    end
    @(negedge clk);
    share_rd = 1'b0;
    if (share_count < push_count) begin
      timeout_errors++;
      $display("timeout at %0t: share queue did not drain", $time);
    end
  endtask

  initial begin
    logic [ROW_W-1:0] r;
    void'($urandom(32'he0442340));
    clk = 1'b0;
    rst_n = 1'b0;
    acc = 1'b0;
    div = 1'b0;
    width_mode = 1'b0;
    sign_mode = 1'b0;
    ofifo_valid = 1'b0;
    sfp_in = '0;
    peer_sum = 16'd300;
    peer_empty = 1'b1;
    share_rd = 1'b0;
    exp_wr = 0;
    check_errors = 0;
    timeout_errors = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);

    // width-4 unsigned
    peer_empty = 1'b0;
    for (int i = 0; i < 4; i++) push_row(random_row(2047));
    divide_rows(4);

    // sign mode with lane 0 forced negative
    sign_mode = 1'b1;
    for (int i = 0; i < 4; i++) begin
      r = random_row(4095);
      r[`SFU_PSUM_W-1] = 1'b1;
      push_row(r);
    end
    divide_rows(4);

    // width-8 pairing signed then unsigned
    width_mode = 1'b1;
    for (int i = 0; i < 2; i++) push_row(random_row(4095));
    sign_mode = 1'b0;
    for (int i = 0; i < 2; i++) push_row(random_row(4095));
    divide_rows(4);

    // stall on peer_empty then in-order release
    width_mode = 1'b0;
    peer_empty = 1'b1;
    for (int i = 0; i < 3; i++) push_row(random_row(1023));
    div = 1'b1;
    repeat (6) @(negedge clk);
    div = 1'b0;
    @(negedge clk);
    peer_empty = 1'b0;
    divide_rows(3);

    drain_share();
    repeat (2) @(negedge clk);

    $display("errors: check=%0d timeout=%0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/sfu_pkg.sv
design/sfu_queue_if.sv
design/sfu_fifo.sv
design/sfu_decode.sv
design/sfu_execute.sv
design/sfu_result.sv
design/sfu_top.sv
sim/sfu_tb.sv
